// ==== design/panel_params.svh ====
/* LED panel geometry and command FIFO constants */

`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// Panel size in pixels
`define PANEL_COLS 320
`define PANEL_ROWS 32

// Colour bytes stored per pixel
`define BYTES_PER_PIXEL 2

// Command FIFO entries, equal to the host's starting credit
`define CMD_FIFO_DEPTH 8

`endif

// ==== design/panel_pkg.sv ====
/* Shared panel command types */

`default_nettype none

`include "panel_params.svh"

package panel_pkg;

    typedef logic [$clog2(`PANEL_COLS)-1:0]      col_addr_t;
    typedef logic [$clog2(`PANEL_ROWS)-1:0]      row_addr_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_idx_t;

    // Little endian byte pair on the wire, one value in the walker
    typedef union packed {
        logic [15:0]     value;
        logic [1:0][7:0] bytes;
    } col_addr_field_t;

    // Colour bytes arrive big endian, so bytes[BPP-1] is the first byte
    typedef union packed {
        logic [`BYTES_PER_PIXEL*8-1:0]     word;
        logic [`BYTES_PER_PIXEL-1:0][7:0]  bytes;
    } color_field_t;

    typedef struct packed {
        row_addr_t  row;
        col_addr_t  col;
        pixel_idx_t pixel;
    } fb_addr_t;

    typedef struct packed {
        fb_addr_t    addr;
        logic [7:0]  data;
        logic        we;
    } fb_write_t;

    // y1 and height keep the full operand byte so clipping sees the raw value
    typedef struct packed {
        col_addr_field_t x1;
        logic [7:0]      y1;
        col_addr_field_t width;
        logic [7:0]      height;
        color_field_t    color;
    } rect_t;

endpackage

`default_nettype wire

// ==== design/cmd_dispatch.sv ====
/* Command FIFO and opcode dispatch */

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module cmd_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_valid,
    input  logic [7:0] cmd_byte,
    output logic       credit_return,
    output logic       op_valid,
    output logic [7:0] op_byte,
    input  logic       op_ready,
    output logic       bad_opcode
);

    localparam int DEPTH = `CMD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    // x1 (2), y1 (1), width (2), height (1), colour
    localparam int OPERAND_BYTES = 6 + `BYTES_PER_PIXEL;
    localparam int CNT_W = $clog2(OPERAND_BYTES);

    localparam logic [7:0] OP_NOP      = 8'h00;
    localparam logic [7:0] OP_FILLRECT = 8'h01;

    typedef enum logic {
        ST_OPCODE,
        ST_OPERANDS
    } state_t;

    logic [7:0]       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             empty;
    logic             full;
    logic             push;
    logic             pop;
    logic [7:0]       head;

    state_t           state;
    logic [CNT_W-1:0] operand_cnt;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign push  = cmd_valid;
    assign head  = fifo_mem[rd_ptr];

    // Opcodes are consumed on sight, operands only when the fill block takes them
    assign op_valid = (state == ST_OPERANDS) && !empty;
    assign op_byte  = head;
    assign pop      = (state == ST_OPCODE) ? !empty : (op_valid && op_ready);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count         <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
            credit_return <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_OPCODE;
            operand_cnt <= '0;
            bad_opcode  <= 1'b0;
        end else begin
            bad_opcode <= 1'b0;
            case (state)
                ST_OPCODE: begin
                    if (!empty) begin
                        if (head == OP_FILLRECT) begin
                            state       <= ST_OPERANDS;
                            operand_cnt <= CNT_W'(OPERAND_BYTES - 1);
                        end else if (head != OP_NOP) begin
                            bad_opcode <= 1'b1;
                        end
                    end
                end
                ST_OPERANDS: begin
                    if (pop) begin
                        if (operand_cnt == '0) begin
                            state <= ST_OPCODE;
                        end else begin
                            operand_cnt <= operand_cnt - 1'b1;
                        end
                    end
                end
                default: state <= ST_OPCODE;
            endcase
        end
    end

    // Host must respect its credit count
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("command FIFO overflow");

endmodule

`default_nettype wire

// ==== design/cmd_fillrect.sv ====
/* Fill-rectangle operand capture */

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module cmd_fillrect
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       op_valid,
    input  logic [7:0] op_byte,
    output logic       op_ready,
    output rect_t      rect,
    output logic       start,
    input  logic       area_done,
    output logic       cmd_done
);

    localparam pixel_idx_t FIRST_COLOR_IDX = pixel_idx_t'(`BYTES_PER_PIXEL - 1);

    typedef enum logic [2:0] {
        ST_X1,
        ST_Y1,
        ST_WIDTH,
        ST_HEIGHT,
        ST_COLOR,
        ST_START,
        ST_RUNNING,
        ST_DONE
    } state_t;

    state_t     state;
    logic       byte_idx;
    pixel_idx_t color_idx;
    logic       take;

    assign op_ready = state inside {ST_X1, ST_Y1, ST_WIDTH, ST_HEIGHT, ST_COLOR};
    assign take     = op_valid && op_ready;
    assign start    = (state == ST_START);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_X1;
            byte_idx  <= 1'b0;
            color_idx <= FIRST_COLOR_IDX;
            cmd_done  <= 1'b0;
            rect      <= '0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                ST_X1: begin
                    // Little endian
                    if (take) begin
                        rect.x1.bytes[byte_idx] <= op_byte;
                        byte_idx <= ~byte_idx;
                        if (byte_idx) begin
                            state <= ST_Y1;
                        end
                    end
                end
                ST_Y1: begin
                    if (take) begin
                        rect.y1 <= op_byte;
                        state   <= ST_WIDTH;
                    end
                end
                ST_WIDTH: begin
                    if (take) begin
                        rect.width.bytes[byte_idx] <= op_byte;
                        byte_idx <= ~byte_idx;
                        if (byte_idx) begin
                            state <= ST_HEIGHT;
                        end
                    end
                end
                ST_HEIGHT: begin
                    if (take) begin
                        rect.height <= op_byte;
                        state       <= ST_COLOR;
                    end
                end
                ST_COLOR: begin
                    // Big endian, most significant byte first
                    if (take) begin
                        rect.color.bytes[color_idx] <= op_byte;
                        if (color_idx == '0) begin
                            state <= ST_START;
                        end else begin
                            color_idx <= color_idx - 1'b1;
                        end
                    end
                end
                ST_START: begin
                    state <= ST_RUNNING;
                end
                ST_RUNNING: begin
                    if (area_done) begin
                        cmd_done <= 1'b1;
                        state    <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // Ready for the next command
                    rect      <= '0;
                    byte_idx  <= 1'b0;
                    color_idx <= FIRST_COLOR_IDX;
                    state     <= ST_X1;
                end
                default: state <= ST_X1;
            endcase
        end
    end

    // One walk at a time, finished only while it is awaited
    assert property (@(posedge clk) disable iff (reset)
        area_done |-> (state == ST_RUNNING))
        else $error("area_done outside a running walk");

endmodule

`default_nettype wire

// ==== design/fillarea_walker.sv ====
/* Clipped rectangle area walker */

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module fillarea_walker
    import panel_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  rect_t     rect,
    output fb_write_t wr,
    output logic      area_done
);

    localparam pixel_idx_t LAST_PIXEL = pixel_idx_t'(`BYTES_PER_PIXEL - 1);

    logic [16:0]  col_sum;
    logic [16:0]  col_end;
    logic [8:0]   row_sum;
    logic [8:0]   row_end;
    logic         empty;

    logic         active;
    fb_addr_t     cur;
    col_addr_t    col_first;
    col_addr_t    col_last;
    row_addr_t    row_last;
    color_field_t color_q;

    // Exclusive ends, clipped at the right and bottom panel edges
    assign col_sum = {1'b0, rect.x1.value} + {1'b0, rect.width.value};
    assign col_end = (col_sum > 17'(`PANEL_COLS)) ? 17'(`PANEL_COLS) : col_sum;
    assign row_sum = {1'b0, rect.y1} + {1'b0, rect.height};
    assign row_end = (row_sum > 9'(`PANEL_ROWS)) ? 9'(`PANEL_ROWS) : row_sum;

    assign empty = (rect.width.value == '0) || (rect.height == '0)
                || (rect.x1.value >= 16'(`PANEL_COLS)) || (rect.y1 >= 8'(`PANEL_ROWS));

    assign wr.addr = cur;
    assign wr.data = color_q.bytes[cur.pixel];
    assign wr.we   = active;

    always_ff @(posedge clk) begin
        if (start) begin
            col_first <= col_addr_t'(rect.x1.value);
            col_last  <= col_addr_t'(col_end - 17'd1);
            row_last  <= row_addr_t'(row_end - 9'd1);
            color_q.word <= rect.color.word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            area_done <= 1'b0;
            cur       <= '0;
        end else begin
            area_done <= 1'b0;
            if (start) begin
                cur.row   <= row_addr_t'(rect.y1);
                cur.col   <= col_addr_t'(rect.x1.value);
                cur.pixel <= '0;
                active    <= !empty;
                area_done <= empty;
            end else if (active) begin
                // Pixel byte, then column, then row
                if (cur.pixel == LAST_PIXEL) begin
                    cur.pixel <= '0;
                    if (cur.col == col_last) begin
                        cur.col <= col_first;
                        if (cur.row == row_last) begin
                            active    <= 1'b0;
                            area_done <= 1'b1;
                        end else begin
                            cur.row <= cur.row + 1'b1;
                        end
                    end else begin
                        cur.col <= cur.col + 1'b1;
                    end
                end else begin
                    cur.pixel <= cur.pixel + 1'b1;
                end
            end
        end
    end

    // Row index spans exactly the panel height, so only the column can stray
    assert property (@(posedge clk) disable iff (reset)
        wr.we |-> (wr.addr.col < col_addr_t'(`PANEL_COLS)))
        else $error("framebuffer write outside panel");

endmodule

`default_nettype wire

// ==== design/framebuffer.sv ====
/* Byte-wide framebuffer RAM */

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module framebuffer
    import panel_pkg::*;
(
    input  logic       clk,
    input  fb_write_t  wr,
    input  fb_addr_t   rd_addr,
    output logic [7:0] rd_data
);

    localparam int FB_BYTES = `PANEL_ROWS * `PANEL_COLS * `BYTES_PER_PIXEL;
    localparam int IDX_W    = $clog2(FB_BYTES);

    logic [7:0]       mem [FB_BYTES];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Row-major, pixel bytes adjacent
    function automatic logic [IDX_W-1:0] flat_index(input fb_addr_t a);
        flat_index = IDX_W'((IDX_W'(a.row) * IDX_W'(`PANEL_COLS) + IDX_W'(a.col))
                     * IDX_W'(`BYTES_PER_PIXEL) + IDX_W'(a.pixel));
    endfunction

    assign wr_idx = flat_index(wr.addr);
    assign rd_idx = flat_index(rd_addr);

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_idx] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

endmodule

`default_nettype wire

// ==== design/panel_cmd_top.sv ====
/* LED panel command engine */

`timescale 1ns/1ps
`default_nettype none

module panel_cmd_top
    import panel_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_valid,
    input  logic [7:0] cmd_byte,
    output logic       credit_return,
    input  fb_addr_t   rd_addr,
    output logic [7:0] rd_data,
    output logic       cmd_done,
    output logic       bad_opcode
);

    logic       op_valid;
    logic [7:0] op_byte;
    logic       op_ready;
    rect_t      rect;
    logic       start;
    logic       area_done;
    fb_write_t  wr;

    cmd_dispatch u_cmd_dispatch (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_byte      (cmd_byte),
        .credit_return (credit_return),
        .op_valid      (op_valid),
        .op_byte       (op_byte),
        .op_ready      (op_ready),
        .bad_opcode    (bad_opcode)
    );

    cmd_fillrect u_cmd_fillrect (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op_byte   (op_byte),
        .op_ready  (op_ready),
        .rect      (rect),
        .start     (start),
        .area_done (area_done),
        .cmd_done  (cmd_done)
    );

    fillarea_walker u_fillarea_walker (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rect      (rect),
        .wr        (wr),
        .area_done (area_done)
    );

    framebuffer u_framebuffer (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== tests/tb_panel_cmd.sv ====
/* Panel command engine testbench */

`timescale 1ns/1ps
`default_nettype none

`include "panel_params.svh"

module tb_panel_cmd
    import panel_pkg::*;
();

    localparam int COLS        = `PANEL_COLS;
    localparam int ROWS        = `PANEL_ROWS;
    localparam int BPP         = `BYTES_PER_PIXEL;
    localparam int DEPTH       = `CMD_FIFO_DEPTH;
    localparam int FB_BYTES    = ROWS * COLS * BPP;
    // Opcode, x1 (2), y1, width (2), height, colour
    localparam int CMD_BYTES   = 7 + BPP;
    localparam int TIMEOUT     = 50000;
    localparam int NUM_ENTRIES = 11;
    localparam int NUM_RANDOM  = 8;

    typedef struct packed {
        logic [7:0]       opcode;
        logic [15:0]      x1;
        logic [7:0]       y1;
        logic [15:0]      width;
        logic [7:0]       height;
        logic [BPP*8-1:0] color;
        logic             exp_bad;
    } cmd_entry_t;

    logic       clk;
    logic       reset;
    logic       cmd_valid;
    logic [7:0] cmd_byte;
    logic       credit_return;
    fb_addr_t   rd_addr;
    logic [7:0] rd_data;
    logic       cmd_done;
    logic       bad_opcode;

    logic [7:0]  model [FB_BYTES];
    cmd_entry_t  cmd_table [NUM_ENTRIES];
    logic [31:0] lfsr;
    int          sent_count;
    int          returned_count;
    int          done_count;
    int          bad_count;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    panel_cmd_top u_panel_cmd_top (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_byte      (cmd_byte),
        .credit_return (credit_return),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .cmd_done      (cmd_done),
        .bad_opcode    (bad_opcode)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Pulse counters seen at the host side
    always @(posedge clk) begin
        if (!reset) begin
            if (credit_return) begin
                returned_count <= returned_count + 1;
            end
            if (cmd_done) begin
                done_count <= done_count + 1;
            end
            if (bad_opcode) begin
                bad_count <= bad_count + 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("Test failed");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] value);
        int waited;
        waited = 0;
        // Hold off while every credit is in flight
        while (sent_count - returned_count >= DEPTH) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("credit return");
            end
        end
        cmd_valid = 1'b1;
        cmd_byte  = value;
        sent_count++;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic send_command(input cmd_entry_t e);
        int k;
        send_byte(e.opcode);
        if (e.opcode == 8'h01) begin
            send_byte(e.x1[7:0]);
            send_byte(e.x1[15:8]);
            send_byte(e.y1);
            send_byte(e.width[7:0]);
            send_byte(e.width[15:8]);
            send_byte(e.height);
            // Colour goes most significant byte first
            for (k = BPP - 1; k >= 0; k--) begin
                send_byte(e.color[8*k +: 8]);
            end
        end
    endtask

    task automatic wait_done(input int target);
        int waited;
        waited = 0;
        while (done_count < target) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("cmd_done pulse");
            end
        end
    endtask

    task automatic wait_credits();
        int waited;
        waited = 0;
        while (returned_count < sent_count) begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                report_timeout("return of all credits");
            end
        end
    endtask

    function automatic int fb_index(input int row, input int col, input int pixel);
        return (row * COLS + col) * BPP + pixel;
    endfunction

    // Shadow model with right and bottom clipping
    task automatic model_fill(input cmd_entry_t e);
        int row_end;
        int col_end;
        int row;
        int col;
        int k;
        row_end = int'(e.y1) + int'(e.height);
        col_end = int'(e.x1) + int'(e.width);
        if (row_end > ROWS) begin
            row_end = ROWS;
        end
        if (col_end > COLS) begin
            col_end = COLS;
        end
        for (row = int'(e.y1); row < row_end; row++) begin
            for (col = int'(e.x1); col < col_end; col++) begin
                for (k = 0; k < BPP; k++) begin
                    model[fb_index(row, col, k)] = e.color[8*k +: 8];
                end
            end
        end
    endtask

    task automatic compare_framebuffer();
        int row;
        int col;
        int k;
        for (row = 0; row < ROWS; row++) begin
            for (col = 0; col < COLS; col++) begin
                for (k = 0; k < BPP; k++) begin
                    rd_addr.row   = row_addr_t'(row);
                    rd_addr.col   = col_addr_t'(col);
                    rd_addr.pixel = pixel_idx_t'(k);
                    next_cycle();
                    check_value($sformatf("rd_data row %0d col %0d byte %0d", row, col, k),
                                32'(rd_data), 32'(model[fb_index(row, col, k)]));
                end
            end
        end
        rd_addr = '0;
    endtask

    task automatic report_test(input string label, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, label);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, label, errors - err_before);
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic random_entry(output cmd_entry_t e);
        logic [31:0] bits;
        e        = '0;
        e.opcode = 8'h01;
        random_bits(8, bits);
        e.x1 = 16'(bits);
        random_bits(5, bits);
        e.y1 = 8'(bits);
        random_bits(7, bits);
        e.width = 16'(bits) + 16'd1;
        random_bits(4, bits);
        e.height = 8'(bits) + 8'd1;
        random_bits(BPP * 8, bits);
        e.color = (BPP*8)'(bits);
    endtask

    task automatic load_table();
        // opcode, x1, y1, width, height, colour, bad_opcode
        cmd_table[0]  = '{8'h01, 16'd0,     8'd0,  16'd320,   8'd32, 16'h1234, 1'b0};
        cmd_table[1]  = '{8'h01, 16'd10,    8'd4,  16'd20,    8'd6,  16'hA1B2, 1'b0};
        cmd_table[2]  = '{8'h01, 16'd300,   8'd28, 16'd50,    8'd10, 16'hC3D4, 1'b0};
        cmd_table[3]  = '{8'h01, 16'd0,     8'd0,  16'd3,     8'd2,  16'h0F0E, 1'b0};
        cmd_table[4]  = '{8'h01, 16'h0104,  8'd20, 16'h0120,  8'd3,  16'h5566, 1'b0};
        cmd_table[5]  = '{8'h01, 16'd50,    8'd10, 16'd0,     8'd5,  16'hFFFF, 1'b0};
        cmd_table[6]  = '{8'h01, 16'd50,    8'd10, 16'd5,     8'd0,  16'hEEEE, 1'b0};
        cmd_table[7]  = '{8'h00, 16'd0,     8'd0,  16'd0,     8'd0,  16'h0000, 1'b0};
        cmd_table[8]  = '{8'h7E, 16'd0,     8'd0,  16'd0,     8'd0,  16'h0000, 1'b1};
        cmd_table[9]  = '{8'hFF, 16'd0,     8'd0,  16'd0,     8'd0,  16'h0000, 1'b1};
        cmd_table[10] = '{8'h01, 16'd100,   8'd16, 16'd8,     8'd8,  16'h3C5A, 1'b0};
    endtask

    task automatic run_entry(input cmd_entry_t e);
        int err_before;
        int done_before;
        int bad_before;
        logic is_fill;
        err_before  = errors;
        done_before = done_count;
        bad_before  = bad_count;
        is_fill     = (e.opcode == 8'h01);
        send_command(e);
        if (is_fill) begin
            wait_done(done_before + 1);
            model_fill(e);
        end
        wait_credits();
        repeat (2) next_cycle();
        check_value("cmd_done pulses", 32'(done_count - done_before), 32'(is_fill));
        check_value("bad_opcode pulses", 32'(bad_count - bad_before), 32'(e.exp_bad));
        compare_framebuffer();
        report_test($sformatf("opcode 0x%02h x1 %0d y1 %0d w %0d h %0d", e.opcode,
                              e.x1, e.y1, e.width, e.height), err_before);
    endtask

    // Back to back commands, paced only by credit
    task automatic run_random_burst();
        cmd_entry_t burst [NUM_RANDOM];
        int err_before;
        int done_before;
        int ret_before;
        int i;
        err_before  = errors;
        done_before = done_count;
        ret_before  = returned_count;
        for (i = 0; i < NUM_RANDOM; i++) begin
            random_entry(burst[i]);
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            send_command(burst[i]);
        end
        wait_done(done_before + NUM_RANDOM);
        wait_credits();
        repeat (4) next_cycle();
        // Later command wins on overlap
        for (i = 0; i < NUM_RANDOM; i++) begin
            model_fill(burst[i]);
        end
        check_value("credit_return pulses", 32'(returned_count - ret_before),
                    32'(NUM_RANDOM * CMD_BYTES));
        check_value("cmd_done pulses", 32'(done_count - done_before), 32'(NUM_RANDOM));
        compare_framebuffer();
        report_test($sformatf("random burst of %0d fills", NUM_RANDOM), err_before);
    endtask

    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_byte  = 8'h00;
        rd_addr   = '0;
        lfsr      = 32'd88998;
        load_table();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        for (int n = 0; n < NUM_ENTRIES; n++) begin
            run_entry(cmd_table[n]);
        end
        run_random_burst();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/panel_pkg.sv
design/cmd_dispatch.sv
design/cmd_fillrect.sv
design/fillarea_walker.sv
design/framebuffer.sv
design/panel_cmd_top.sv
tests/tb_panel_cmd.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module tb_panel_cmd

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_panel_cmd \
		--Mdir obj_dir -o tb_panel_cmd
	./obj_dir/tb_panel_cmd > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
